//--- include/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
`define CACHE_SETS       256
`define CACHE_WORD_BITS  32
`define CACHE_LINE_WORDS 4
`define CACHE_WAYS       2

// victim selection, must be nonzero
`define CACHE_LFSR_SEED  8'hA5

`endif

//--- verilog/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

    localparam int addr_bits   = 32;
    localparam int index_bits  = $clog2(`CACHE_SETS);
    localparam int offset_bits = $clog2(`CACHE_LINE_WORDS * `CACHE_WORD_BITS / 8);
    localparam int tag_bits    = addr_bits - index_bits - offset_bits;

    // address fields
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [offset_bits-1:0] offset_t;

    // data payloads
    typedef logic [`CACHE_WORD_BITS-1:0]   word_t;
    typedef logic [`CACHE_WORD_BITS/8-1:0] strb_t;
    typedef word_t [`CACHE_LINE_WORDS-1:0] line_t;

    // valid sits in the low bit
    typedef struct packed {
        tag_t tag;
        logic valid;
    } tag_entry_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss,
        st_replace,
        st_refill
    } ctrl_state_t;

endpackage

//--- verilog/way_if.sv
`timescale 1ns/1ps

interface way_if;
    import cache_pkg::*;

    // read side, data one cycle after rd_en
    logic       rd_en;
    index_t     index;
    tag_entry_t tag_rd;
    line_t      line_rd;
    logic       dirty_rd;

    // write side, shares index with the read
    logic       tag_we;
    logic       line_we;
    logic       dirty_we;
    tag_entry_t tag_wr;
    line_t      line_wr;
    logic       dirty_wr;

    modport ctrl (
        output rd_en, index, tag_we, line_we, dirty_we, tag_wr, line_wr, dirty_wr,
        input  tag_rd, line_rd, dirty_rd
    );

    modport way (
        input  rd_en, index, tag_we, line_we, dirty_we, tag_wr, line_wr, dirty_wr,
        output tag_rd, line_rd, dirty_rd
    );

endinterface

//--- verilog/set_ram.sv
`timescale 1ns/1ps

module set_ram #(
    parameter type entry_t = logic,
    parameter int  depth   = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rd_en,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic                     we,
    input  entry_t                   wr_data,
    output entry_t                   rd_data
);

    entry_t mem [depth];

    // rst sweeps every entry to zero, tied low for payloads without reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wr_data;
        end
    end

    // read before write on the same address
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[addr];
        end
    end

endmodule

//--- verilog/cache_way.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_way (
    input logic clk,
    input logic rst,
    way_if.way  port
);
    import cache_pkg::*;

    logic [`CACHE_SETS-1:0] dirty;

    // tag entries, valid bits swept on reset
    set_ram #(
        .entry_t (tag_entry_t),
        .depth   (`CACHE_SETS)
    ) u_tag_ram (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (port.rd_en),
        .addr    (port.index),
        .we      (port.tag_we),
        .wr_data (port.tag_wr),
        .rd_data (port.tag_rd)
    );

    // line data
    set_ram #(
        .entry_t (line_t),
        .depth   (`CACHE_SETS)
    ) u_line_ram (
        .clk     (clk),
        .rst     (1'b0),
        .rd_en   (port.rd_en),
        .addr    (port.index),
        .we      (port.line_we),
        .wr_data (port.line_wr),
        .rd_data (port.line_rd)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            dirty <= '0;
        end else if (port.dirty_we) begin
            dirty[port.index] <= port.dirty_wr;
        end
    end

    // same latency and hold behaviour as the rams
    always_ff @(posedge clk) begin
        if (port.rd_en) begin
            port.dirty_rd <= dirty[port.index];
        end
    end

endmodule

//--- verilog/victim_lfsr.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module victim_lfsr (
    input  logic clk,
    input  logic rst,
    output logic rand_bit
);

    logic [7:0] lfsr;
    logic       feedback;

    // x^8 + x^6 + x^5 + x^4 + 1, period 255
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= `CACHE_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], feedback};
        end
    end

    assign rand_bit = lfsr[0];

endmodule

//--- verilog/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    // cpu side
    input  logic                             valid,
    input  logic                             op,
    input  cache_pkg::index_t                index,
    input  cache_pkg::tag_t                  tag,
    input  cache_pkg::offset_t               offset,
    input  cache_pkg::strb_t                 wstrb,
    input  cache_pkg::word_t                 wdata,
    output logic                             addr_ok,
    output logic                             data_ok,
    output cache_pkg::word_t                 rdata,
    // memory side
    output logic                             rd_req,
    output logic [cache_pkg::addr_bits-1:0]  rd_addr,
    input  logic                             rd_rdy,
    input  logic                             ret_valid,
    input  logic                             ret_last,
    input  cache_pkg::word_t                 ret_data,
    output logic                             wr_req,
    output logic [cache_pkg::addr_bits-1:0]  wr_addr,
    output cache_pkg::line_t                 wr_data,
    input  logic                             wr_rdy,
    input  logic                             rand_bit,
    way_if.ctrl                              way0,
    way_if.ctrl                              way1
);
    import cache_pkg::*;

    localparam int byte_bits = $clog2(`CACHE_WORD_BITS / 8);
    localparam int sel_bits  = $clog2(`CACHE_LINE_WORDS);

    ctrl_state_t state;
    ctrl_state_t state_next;

    // request buffer
    logic    op_reg;
    index_t  index_reg;
    tag_t    tag_reg;
    offset_t offset_reg;
    strb_t   wstrb_reg;
    word_t   wdata_reg;

    logic [sel_bits-1:0]              word_sel;
    logic [$clog2(`CACHE_WAYS)-1:0]   victim;
    logic [sel_bits-1:0]              refill_cnt;
    line_t                            refill_buf;

    logic       hit0;
    logic       hit1;
    logic       hit;
    line_t      hit_line;
    line_t      merged_line;
    tag_entry_t victim_tag;
    line_t      victim_line;
    logic       victim_dirty;
    word_t      refill_word;
    line_t      fill_line;
    logic       fill_done;
    logic       hit_write;
    logic       sel0;
    logic       sel1;
    line_t      line_wr;

    function automatic word_t merge_word(input word_t old_word, input word_t new_word,
                                         input strb_t strb);
        word_t result;
        result = old_word;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            op_reg     <= op;
            index_reg  <= index;
            tag_reg    <= tag;
            offset_reg <= offset;
            wstrb_reg  <= wstrb;
            wdata_reg  <= wdata;
        end
    end

    assign word_sel = offset_reg[$bits(offset_t)-1:byte_bits];

    // lookup, tag entries arrive the cycle after acceptance
    assign hit0 = way0.tag_rd.valid && (way0.tag_rd.tag == tag_reg);
    assign hit1 = way1.tag_rd.valid && (way1.tag_rd.tag == tag_reg);
    assign hit  = hit0 || hit1;

    assign hit_line = hit1 ? way1.line_rd : way0.line_rd;

    always_comb begin
        merged_line           = hit_line;
        merged_line[word_sel] = merge_word(hit_line[word_sel], wdata_reg, wstrb_reg);
    end

    // way outputs still hold the lookup read during miss
    assign victim_tag   = (victim != '0) ? way1.tag_rd   : way0.tag_rd;
    assign victim_line  = (victim != '0) ? way1.line_rd  : way0.line_rd;
    assign victim_dirty = (victim != '0) ? way1.dirty_rd : way0.dirty_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            victim <= '0;
        end else if (state == st_lookup && !hit) begin
            victim <= rand_bit;
        end
    end

    // refill, pending write lands on its word as it streams in
    assign refill_word = (op_reg && refill_cnt == word_sel) ?
                         merge_word(ret_data, wdata_reg, wstrb_reg) : ret_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            refill_cnt <= '0;
        end else if (state == st_refill && ret_valid) begin
            refill_cnt <= ret_last ? '0 : refill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_refill && ret_valid) begin
            refill_buf[refill_cnt] <= refill_word;
        end
    end

    // last word goes straight into the ram write
    always_comb begin
        fill_line             = refill_buf;
        fill_line[refill_cnt] = refill_word;
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (valid) begin
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                state_next = hit ? st_idle : st_miss;
            end
            st_miss: begin
                if (!wr_req || wr_rdy) begin
                    state_next = st_replace;
                end
            end
            st_replace: begin
                if (rd_rdy) begin
                    state_next = st_refill;
                end
            end
            st_refill: begin
                if (ret_valid && ret_last) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // cpu responses
    assign addr_ok = (state == st_idle);
    assign data_ok = (state == st_lookup && hit) ||
                     (state == st_refill && ret_valid && refill_cnt == word_sel);
    assign rdata   = (state == st_refill) ? ret_data : hit_line[word_sel];

    // memory requests
    assign wr_req  = (state == st_miss) && victim_tag.valid && victim_dirty;
    assign wr_addr = {victim_tag.tag, index_reg, offset_t'(0)};
    assign wr_data = victim_line;
    assign rd_req  = (state == st_replace);
    assign rd_addr = {tag_reg, index_reg, offset_t'(0)};

    // way writes, refill goes to the victim and a write hit to the hit way
    assign fill_done = (state == st_refill) && ret_valid && ret_last;
    assign hit_write = (state == st_lookup) && hit && op_reg;
    assign sel0      = fill_done ? (victim == '0) : hit0;
    assign sel1      = fill_done ? (victim != '0) : hit1;
    assign line_wr   = fill_done ? fill_line : merged_line;

    assign way0.rd_en    = valid && addr_ok;
    assign way0.index    = addr_ok ? index : index_reg;
    assign way0.tag_we   = fill_done && sel0;
    assign way0.tag_wr   = '{tag: tag_reg, valid: 1'b1};
    assign way0.line_we  = (fill_done || hit_write) && sel0;
    assign way0.line_wr  = line_wr;
    assign way0.dirty_we = (fill_done || hit_write) && sel0;
    assign way0.dirty_wr = op_reg;

    assign way1.rd_en    = valid && addr_ok;
    assign way1.index    = addr_ok ? index : index_reg;
    assign way1.tag_we   = fill_done && sel1;
    assign way1.tag_wr   = '{tag: tag_reg, valid: 1'b1};
    assign way1.line_we  = (fill_done || hit_write) && sel1;
    assign way1.line_wr  = line_wr;
    assign way1.dirty_we = (fill_done || hit_write) && sel1;
    assign way1.dirty_wr = op_reg;

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                             clk,
    input  logic                             rst,
    // cpu side
    input  logic                             valid,
    input  logic                             op,
    input  cache_pkg::index_t                index,
    input  cache_pkg::tag_t                  tag,
    input  cache_pkg::offset_t               offset,
    input  cache_pkg::strb_t                 wstrb,
    input  cache_pkg::word_t                 wdata,
    output logic                             addr_ok,
    output logic                             data_ok,
    output cache_pkg::word_t                 rdata,
    // memory side
    output logic                             rd_req,
    output logic [cache_pkg::addr_bits-1:0]  rd_addr,
    input  logic                             rd_rdy,
    input  logic                             ret_valid,
    input  logic                             ret_last,
    input  cache_pkg::word_t                 ret_data,
    output logic                             wr_req,
    output logic [cache_pkg::addr_bits-1:0]  wr_addr,
    output cache_pkg::line_t                 wr_data,
    input  logic                             wr_rdy
);

    logic rand_bit;

    way_if way0_if ();
    way_if way1_if ();

    victim_lfsr u_lfsr (
        .clk      (clk),
        .rst      (rst),
        .rand_bit (rand_bit)
    );

    cache_way u_way0 (
        .clk  (clk),
        .rst  (rst),
        .port (way0_if)
    );

    cache_way u_way1 (
        .clk  (clk),
        .rst  (rst),
        .port (way1_if)
    );

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .rand_bit  (rand_bit),
        .way0      (way0_if),
        .way1      (way1_if)
    );

endmodule

//--- verif/axi_mem.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module axi_mem (
    input  logic             clk,
    input  logic             rst,
    input  logic             rd_req,
    input  logic [31:0]      rd_addr,
    output logic             rd_rdy,
    output logic             ret_valid,
    output logic             ret_last,
    output cache_pkg::word_t ret_data,
    input  logic             wr_req,
    input  logic [31:0]      wr_addr,
    input  cache_pkg::line_t wr_data,
    output logic             wr_rdy
);
    import cache_pkg::*;

    word_t       store [logic [29:0]];
    int          rd_wait;
    int          wr_wait;
    int          ret_left;
    logic [29:0] ret_addr;

    // power-up contents, a function of the whole word address
    function automatic word_t fill_word(input logic [29:0] waddr);
        return ({2'b00, waddr} * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic word_t load_word(input logic [29:0] waddr);
        return store.exists(waddr) ? store[waddr] : fill_word(waddr);
    endfunction

    initial begin
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            ret_left  <= 0;
        end else begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            // ready after a random wait of 0 to 3 cycles
            if (rd_req && !rd_rdy) begin
                if (rd_wait == 0) begin
                    rd_rdy  <= 1'b1;
                    rd_wait <= $urandom_range(3, 0);
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
            if (wr_req && !wr_rdy) begin
                if (wr_wait == 0) begin
                    wr_rdy  <= 1'b1;
                    wr_wait <= $urandom_range(3, 0);
                end else begin
                    wr_wait <= wr_wait - 1;
                end
            end
            // write-back is stored before any later refill reads it
            if (wr_req && wr_rdy) begin
                for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
                    store[{wr_addr[31:4], w[1:0]}] = wr_data[w];
                end
            end
            // burst with random gaps between words
            if (rd_req && rd_rdy) begin
                ret_addr <= rd_addr[31:2];
                ret_left <= `CACHE_LINE_WORDS;
            end else if (ret_left != 0 && $urandom_range(3, 0) != 0) begin
                ret_valid <= 1'b1;
                ret_last  <= (ret_left == 1);
                ret_data  <= load_word(ret_addr);
                ret_addr  <= ret_addr + 1'b1;
                ret_left  <= ret_left - 1;
            end
        end
    end

endmodule

//--- verif/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;
    import cache_pkg::*;

    localparam int num_requests = 2000;
    localparam int wait_limit   = 200;

    logic        clk;
    logic        rst;
    logic        valid;
    logic        op;
    index_t      index;
    tag_t        tag;
    offset_t     offset;
    strb_t       wstrb;
    word_t       wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    logic [31:0] wr_addr;
    line_t       wr_data;
    logic        wr_rdy;

    // cpu view of memory by word address
    word_t  golden [logic [29:0]];
    // lines written since their last fill
    bit     written [logic [27:0]];
    tag_t   tag_pool [3] = '{20'h00012, 20'h7ABCD, 20'hFFFFF};
    index_t index_pool [4] = '{8'h00, 8'h31, 8'h80, 8'hFF};
    logic   refilled;

    cache_top uut (.*);

    axi_mem mem (.*);

    // same pattern the memory powers up with
    function automatic word_t fill_word(input logic [29:0] waddr);
        return ({2'b00, waddr} * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic word_t golden_word(input logic [29:0] waddr);
        return golden.exists(waddr) ? golden[waddr] : fill_word(waddr);
    endfunction

    function automatic line_t golden_line(input logic [31:0] addr);
        line_t result;
        for (int w = 0; w < 4; w++) begin
            result[w] = golden_word({addr[31:4], w[1:0]});
        end
        return result;
    endfunction

    // byte lanes with a strobe take the new data
    function automatic word_t apply_strobes(input word_t old_word, input word_t new_word,
                                            input strb_t strb);
        word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic bit line_written(input logic [27:0] line_addr);
        return written.exists(line_addr) && written[line_addr];
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] time %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] time %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] time %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] time %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    // handshakes as seen at the edge just taken
    task automatic watch_memory_traffic(input tag_t req_tag, input index_t req_index);
        if (rd_req && rd_rdy) begin
            refilled = 1'b1;
            check_addr(rd_addr, {req_tag, req_index, 4'h0}, "refill address");
            check_flag(line_written(rd_addr[31:4]), 1'b0, "refill of a line with lost writes");
        end
        if (wr_req && wr_rdy) begin
            check_addr(wr_addr, {wr_addr[31:4], 4'h0}, "write-back alignment");
            check_line(wr_data, golden_line(wr_addr), "write-back data");
            check_flag(line_written(wr_addr[31:4]), 1'b1, "write-back of an unwritten line");
            written[wr_addr[31:4]] = 1'b0;
        end
    endtask

    task automatic run_request(input logic req_op, input tag_t req_tag, input index_t req_index,
                               input offset_t req_offset, input strb_t req_strb,
                               input word_t req_data, input bit expect_hit);
        logic [29:0] waddr;
        int          cycles;
        waddr = {req_tag, req_index, req_offset[3:2]};
        valid  <= 1'b1;
        op     <= req_op;
        tag    <= req_tag;
        index  <= req_index;
        offset <= req_offset;
        wstrb  <= req_strb;
        wdata  <= req_data;
        cycles = 0;
        do begin
            @(posedge clk);
            watch_memory_traffic(req_tag, req_index);
            cycles++;
            if (cycles > wait_limit) begin
                stop_run("timeout: addr_ok never accepted the request");
            end
        end while (!addr_ok);
        valid    <= 1'b0;
        refilled = 1'b0;
        cycles   = 0;
        do begin
            @(posedge clk);
            watch_memory_traffic(req_tag, req_index);
            check_flag(addr_ok, 1'b0, "addr_ok while a request is in flight");
            cycles++;
            if (cycles > wait_limit) begin
                stop_run("timeout: data_ok never came for an accepted request");
            end
        end while (!data_ok);
        // the line used by the previous request is still resident
        if (expect_hit) begin
            check_flag(refilled, 1'b0, "miss on the line the previous request used");
        end
        // one-cycle response exactly when no refill was needed
        check_flag(cycles == 1, !refilled, "hit response timing");
        if (req_op) begin
            golden[waddr] = apply_strobes(golden_word(waddr), req_data, req_strb);
            written[waddr[29:2]] = 1'b1;
        end else begin
            check_word(rdata, golden_word(waddr), "read data");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        logic        req_op;
        tag_t        req_tag;
        index_t      req_index;
        offset_t     req_offset;
        logic        last_write;
        logic [1:0]  pick;
        logic [27:0] prev_line;
        bit          have_prev;
        bit          same_line;
        void'($urandom(73));
        rst    <= 1'b1;
        valid  <= 1'b0;
        op     <= 1'b0;
        index  <= '0;
        tag    <= '0;
        offset <= '0;
        wstrb  <= '0;
        wdata  <= '0;
        last_write = 1'b0;
        req_tag    = tag_pool[0];
        req_index  = index_pool[0];
        req_offset = '0;
        prev_line  = '0;
        have_prev  = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag(addr_ok, 1'b1, "addr_ok after reset");
        check_flag(data_ok, 1'b0, "data_ok after reset");
        check_flag(rd_req, 1'b0, "rd_req after reset");
        check_flag(wr_req, 1'b0, "wr_req after reset");
        for (int n = 0; n < num_requests; n++) begin
            // now and then read back the word just written
            if (last_write && $urandom_range(3, 0) == 0) begin
                req_op = 1'b0;
            end else begin
                req_op     = ($urandom_range(1, 0) == 1);
                pick       = 2'($urandom_range(2, 0));
                req_tag    = tag_pool[pick];
                pick       = 2'($urandom_range(3, 0));
                req_index  = index_pool[pick];
                req_offset = offset_t'($urandom());
            end
            same_line = have_prev && (prev_line == {req_tag, req_index});
            run_request(req_op, req_tag, req_index, req_offset, strb_t'($urandom()), $urandom(),
                        same_line);
            last_write = req_op;
            prev_line  = {req_tag, req_index};
            have_prev  = 1'b1;
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
verilog/cache_pkg.sv
verilog/way_if.sv
verilog/set_ram.sv
verilog/cache_way.sv
verilog/victim_lfsr.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
verif/axi_mem.sv
verif/tb_cache.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f vlog.f --top-module tb_cache -o tb_cache
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_cache
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit 1
fi

exit 0
